//--- hw/core_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Core package
// Widths, the opcode set and the structs passed between the stages of the
// channelised core
////////////////////////////////////////////////////////////////////////////

package core_pkg;

    localparam int unsigned data_width       = 32;
    localparam int unsigned instr_width      = 32;
    localparam int unsigned prog_depth       = 64;
    localparam int unsigned pc_width         = 6;
    localparam int unsigned regs_per_channel = 16;
    localparam int unsigned reg_addr_width   = 4;
    localparam int unsigned max_channels     = 4;
    localparam int unsigned channel_width    = 2;

    // Register bank address is the channel followed by the register
    localparam int unsigned bank_addr_width  = channel_width + reg_addr_width;

    typedef enum logic [4:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_shl,
        op_shr,
        op_ldi,
        op_stop
    } opcode_e;

    typedef struct packed {
        opcode_e                   opcode;
        logic [reg_addr_width-1:0] dest;
        logic [reg_addr_width-1:0] src_a;
        logic [reg_addr_width-1:0] src_b;
        logic [2:0]                spare;
        logic [11:0]               imm;
    } instr_t;

    typedef struct packed {
        instr_t                   instr;
        logic [channel_width-1:0] channel;
    } fetch_t;

    typedef struct packed {
        opcode_e                   opcode;
        logic [channel_width-1:0]  channel;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     operand_a;
        logic [data_width-1:0]     operand_b;
        logic [11:0]               imm;
    } operation_t;

    typedef struct packed {
        logic [channel_width-1:0]  channel;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     value;
    } writeback_t;

    // Opcodes that leave a result in the register file
    function automatic logic writes_reg(opcode_e opcode);
        return opcode inside {op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr, op_ldi};
    endfunction

endpackage

//--- hw/program_store.sv
////////////////////////////////////////////////////////////////////////////
// Program store
// Single program memory, written by the host, read with one cycle latency
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module program_store (
    input  logic                         clock,
    input  logic                         prog_write,
    input  logic [core_pkg::pc_width-1:0] prog_addr,
    input  core_pkg::instr_t             prog_data,
    input  logic [core_pkg::pc_width-1:0] rd_addr,
    output core_pkg::instr_t             rd_data
);

    core_pkg::instr_t mem [core_pkg::prog_depth];

    // Host load port
    always_ff @(posedge clock) begin
        if (prog_write) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Registered read towards the sequencer
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hw/sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Sequencer
// Walks the program counter and repeats every word over the active
// channels, handing each one to the decoder under valid/ready
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sequencer (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic [core_pkg::channel_width-1:0] n_channels,
    output logic [core_pkg::pc_width-1:0]      prog_addr_rd,
    input  core_pkg::instr_t                  prog_word,
    output core_pkg::fetch_t                  fetch,
    output logic                              fetch_valid,
    input  logic                              fetch_ready,
    input  logic                              stop_seen,
    input  logic                              pipe_empty,
    output logic                              done
);

    typedef enum logic [1:0] {idle, read, issue, drain} state_e;

    state_e                             state;
    logic [core_pkg::pc_width-1:0]      pc;
    logic [core_pkg::channel_width-1:0] channel;
    logic                               transfer;
    logic                               last_channel;
    logic                               last_word;

    assign transfer     = fetch_valid && fetch_ready;
    assign last_channel = (channel == n_channels);
    assign last_word    = (pc == core_pkg::pc_width'(core_pkg::prog_depth - 1));

    assign prog_addr_rd  = pc;
    assign fetch_valid   = (state == issue);
    assign fetch.instr   = prog_word;
    assign fetch.channel = channel;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            pc      <= '0;
            channel <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (run) begin
                        pc      <= '0;
                        channel <= '0;
                        state   <= read;
                    end
                end
                // Store output is valid one cycle after the address moves
                read: state <= issue;
                issue: begin
                    if (transfer) begin
                        if (last_channel) begin
                            channel <= '0;
                            // Stop word or end of store closes the run
                            if (stop_seen || last_word) begin
                                state <= drain;
                            end else begin
                                pc    <= pc + 1'b1;
                                state <= read;
                            end
                        end else begin
                            channel <= channel + 1'b1;
                        end
                    end
                end
                drain: begin
                    if (pipe_empty) begin
                        done  <= 1'b1;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

//--- hw/decoder.sv
////////////////////////////////////////////////////////////////////////////
// Decoder
// Reads both operands, stalls on results still in flight and issues the
// expanded operation to the executor
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decoder (
    input  logic                                clock,
    input  logic                                rst_n,
    input  core_pkg::fetch_t                    fetch,
    input  logic                                fetch_valid,
    output logic                                fetch_ready,
    output logic [core_pkg::bank_addr_width-1:0] rd_addr_a,
    output logic [core_pkg::bank_addr_width-1:0] rd_addr_b,
    input  logic [core_pkg::data_width-1:0]      rd_data_a,
    input  logic [core_pkg::data_width-1:0]      rd_data_b,
    output core_pkg::operation_t                op,
    output logic                                op_valid,
    output logic                                stop_seen,
    output logic                                pipe_empty
);

    // Scoreboard, one entry for the decode stage and one for execute
    logic                                dec_busy;
    logic                                exe_busy;
    logic [core_pkg::bank_addr_width-1:0] dec_addr;
    logic [core_pkg::bank_addr_width-1:0] exe_addr;

    logic reads_sources;
    logic hit_a;
    logic hit_b;
    logic accept;

    assign rd_addr_a = {fetch.channel, fetch.instr.src_a};
    assign rd_addr_b = {fetch.channel, fetch.instr.src_b};

    // ldi, nop and stop never look at their source fields
    assign reads_sources = core_pkg::writes_reg(fetch.instr.opcode)
                           && (fetch.instr.opcode != core_pkg::op_ldi);

    assign hit_a = (dec_busy && dec_addr == rd_addr_a) || (exe_busy && exe_addr == rd_addr_a);
    assign hit_b = (dec_busy && dec_addr == rd_addr_b) || (exe_busy && exe_addr == rd_addr_b);

    assign fetch_ready = !(reads_sources && (hit_a || hit_b));
    assign accept      = fetch_valid && fetch_ready;
    assign stop_seen   = accept && (fetch.instr.opcode == core_pkg::op_stop);
    assign pipe_empty  = !dec_busy && !exe_busy;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
            dec_busy <= 1'b0;
            exe_busy <= 1'b0;
        end else begin
            op_valid <= accept;
            dec_busy <= accept && core_pkg::writes_reg(fetch.instr.opcode);
            exe_busy <= dec_busy;
        end
    end

    always_ff @(posedge clock) begin
        dec_addr <= {fetch.channel, fetch.instr.dest};
        exe_addr <= dec_addr;
        if (accept) begin
            op <= '{opcode:    fetch.instr.opcode,
                    channel:   fetch.channel,
                    dest:      fetch.instr.dest,
                    operand_a: rd_data_a,
                    operand_b: rd_data_b,
                    imm:       fetch.instr.imm};
        end
    end

endmodule

//--- hw/executor.sv
////////////////////////////////////////////////////////////////////////////
// Executor
// Registered ALU, turns an operation into a write-back for its channel
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module executor (
    input  logic                 clock,
    input  logic                 rst_n,
    input  core_pkg::operation_t op,
    input  logic                 op_valid,
    output core_pkg::writeback_t wb,
    output logic                 wb_valid
);

    logic [core_pkg::data_width-1:0] result;
    logic [4:0]                      shift;

    // Shift amount from the low bits of operand b
    assign shift = op.operand_b[4:0];

    always_comb begin
        case (op.opcode)
            core_pkg::op_add: result = op.operand_a + op.operand_b;
            core_pkg::op_sub: result = op.operand_a - op.operand_b;
            core_pkg::op_and: result = op.operand_a & op.operand_b;
            core_pkg::op_or:  result = op.operand_a | op.operand_b;
            core_pkg::op_xor: result = op.operand_a ^ op.operand_b;
            core_pkg::op_shl: result = op.operand_a << shift;
            core_pkg::op_shr: result = op.operand_a >> shift;
            core_pkg::op_ldi: result = core_pkg::data_width'(op.imm);
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= op_valid && core_pkg::writes_reg(op.opcode);
        end
    end

    always_ff @(posedge clock) begin
        if (op_valid) begin
            wb.channel <= op.channel;
            wb.dest    <= op.dest;
            wb.value   <= result;
        end
    end

endmodule

//--- hw/register_file.sv
////////////////////////////////////////////////////////////////////////////
// Register file
// Sixteen registers per channel, two operand reads, write-back and a
// host port for preload and readback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module register_file (
    input  logic                                clock,
    input  core_pkg::writeback_t                wb,
    input  logic                                wb_valid,
    input  logic [core_pkg::bank_addr_width-1:0] rd_addr_a,
    output logic [core_pkg::data_width-1:0]      rd_data_a,
    input  logic [core_pkg::bank_addr_width-1:0] rd_addr_b,
    output logic [core_pkg::data_width-1:0]      rd_data_b,
    input  logic                                host_write,
    input  logic [core_pkg::bank_addr_width-1:0] host_addr,
    input  logic [core_pkg::data_width-1:0]      host_wdata,
    output logic [core_pkg::data_width-1:0]      host_rdata
);

    // Power-up contents are zero
    logic [core_pkg::data_width-1:0] regs [core_pkg::max_channels * core_pkg::regs_per_channel]
        = '{default: '0};

    // Write-back wins over the host port
    always @(posedge clock) begin
        if (wb_valid) begin
            regs[{wb.channel, wb.dest}] <= wb.value;
        end else if (host_write) begin
            regs[host_addr] <= host_wdata;
        end
    end

    assign rd_data_a  = regs[rd_addr_a];
    assign rd_data_b  = regs[rd_addr_b];
    assign host_rdata = regs[host_addr];

endmodule

//--- hw/core_top.sv
////////////////////////////////////////////////////////////////////////////
// Channelised core
// Sequencer, decoder, executor and banked registers behind a host port
// for program load, register access and run control
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_top (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               prog_write,
    input  logic [core_pkg::pc_width-1:0]       prog_addr,
    input  core_pkg::instr_t                   prog_data,
    input  logic                               reg_write,
    input  logic [core_pkg::channel_width-1:0]  reg_channel,
    input  logic [core_pkg::reg_addr_width-1:0] reg_addr,
    input  logic [core_pkg::data_width-1:0]     reg_wdata,
    output logic [core_pkg::data_width-1:0]     reg_rdata,
    input  logic [core_pkg::channel_width-1:0]  n_channels,
    input  logic                               run,
    output logic                               done
);

    logic [core_pkg::pc_width-1:0]        prog_addr_rd;
    core_pkg::instr_t                     prog_word;
    core_pkg::fetch_t                     fetch;
    logic                                 fetch_valid;
    logic                                 fetch_ready;
    logic                                 stop_seen;
    logic                                 pipe_empty;
    logic [core_pkg::bank_addr_width-1:0] rd_addr_a;
    logic [core_pkg::bank_addr_width-1:0] rd_addr_b;
    logic [core_pkg::data_width-1:0]      rd_data_a;
    logic [core_pkg::data_width-1:0]      rd_data_b;
    core_pkg::operation_t                 op;
    logic                                 op_valid;
    core_pkg::writeback_t                 wb;
    logic                                 wb_valid;
    logic [core_pkg::bank_addr_width-1:0] host_addr;

    assign host_addr = {reg_channel, reg_addr};

    ///////////////////////////////////////////////////////////////////////////
    // Pipeline
    ///////////////////////////////////////////////////////////////////////////

    sequencer u_sequencer (
        .clock(clock), .rst_n(rst_n), .run(run), .n_channels(n_channels),
        .prog_addr_rd(prog_addr_rd), .prog_word(prog_word),
        .fetch(fetch), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
        .stop_seen(stop_seen), .pipe_empty(pipe_empty), .done(done)
    );

    decoder u_decoder (
        .clock(clock), .rst_n(rst_n),
        .fetch(fetch), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .op(op), .op_valid(op_valid), .stop_seen(stop_seen), .pipe_empty(pipe_empty)
    );

    executor u_executor (
        .clock(clock), .rst_n(rst_n), .op(op), .op_valid(op_valid),
        .wb(wb), .wb_valid(wb_valid)
    );

    ///////////////////////////////////////////////////////////////////////////
    // Storage
    ///////////////////////////////////////////////////////////////////////////

    program_store u_program_store (
        .clock(clock), .prog_write(prog_write), .prog_addr(prog_addr),
        .prog_data(prog_data), .rd_addr(prog_addr_rd), .rd_data(prog_word)
    );

    register_file u_register_file (
        .clock(clock), .wb(wb), .wb_valid(wb_valid),
        .rd_addr_a(rd_addr_a), .rd_data_a(rd_data_a),
        .rd_addr_b(rd_addr_b), .rd_data_b(rd_data_b),
        .host_write(reg_write), .host_addr(host_addr),
        .host_wdata(reg_wdata), .host_rdata(reg_rdata)
    );

endmodule

//--- tb/core_props.sv
////////////////////////////////////////////////////////////////////////////
// Core properties
// Handshake, reset and done checks, bound into the core top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_props (
    input logic             clock,
    input logic             rst_n,
    input core_pkg::fetch_t fetch,
    input logic             fetch_valid,
    input logic             fetch_ready,
    input logic             op_valid,
    input logic             done
);

    // Number of property failures so far
    int unsigned error_count = 0;

    // A stalled fetch keeps its contents
    assert property (@(posedge clock) disable iff (!rst_n)
        fetch_valid && !fetch_ready |=> $stable(fetch))
        else begin
            $error("fetch changed while stalled");
            error_count++;
        end

    // Valid is only withdrawn by a transfer
    assert property (@(posedge clock) disable iff (!rst_n)
        fetch_valid && !fetch_ready |=> fetch_valid)
        else begin
            $error("fetch_valid dropped without a transfer");
            error_count++;
        end

    assert property (@(posedge clock) $rose(rst_n) |-> !op_valid)
        else begin
            $error("op_valid high after reset");
            error_count++;
        end

    assert property (@(posedge clock) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done longer than one cycle");
            error_count++;
        end

endmodule

// Handshake and done are all visible at the top level
bind core_top core_props i_props (
    .clock(clock), .rst_n(rst_n), .fetch(fetch), .fetch_valid(fetch_valid),
    .fetch_ready(fetch_ready), .op_valid(op_valid), .done(done)
);

//--- tb/core_tb.sv
////////////////////////////////////////////////////////////////////////////
// Core testbench
// Loads directed and random programs, runs them over one to four channels
// and compares every register bank with a reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_tb;

    localparam int unsigned num_runs     = 26;
    localparam int unsigned run_cycles   = core_pkg::prog_depth * core_pkg::max_channels * 3 + 50;
    localparam int unsigned done_timeout = 2000;
    localparam int unsigned bank_words   = core_pkg::max_channels * core_pkg::regs_per_channel;

    logic                               clock;
    logic                               rst_n;
    logic                               prog_write;
    logic [core_pkg::pc_width-1:0]       prog_addr;
    core_pkg::instr_t                   prog_data;
    logic                               reg_write;
    logic [core_pkg::channel_width-1:0]  reg_channel;
    logic [core_pkg::reg_addr_width-1:0] reg_addr;
    logic [core_pkg::data_width-1:0]     reg_wdata;
    logic [core_pkg::data_width-1:0]     reg_rdata;
    logic [core_pkg::channel_width-1:0]  n_channels;
    logic                               run;
    logic                               done;

    core_pkg::instr_t prog_mem [core_pkg::prog_depth];
    logic [31:0]      model_regs [bank_words];
    logic [15:0]      lfsr_state;
    int unsigned      stop_pos;

    core_top i_dut (
        .clock(clock), .rst_n(rst_n), .prog_write(prog_write), .prog_addr(prog_addr),
        .prog_data(prog_data), .reg_write(reg_write), .reg_channel(reg_channel),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .n_channels(n_channels), .run(run), .done(done)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] random_bits(input int unsigned count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int unsigned i = 0; i < count; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic core_pkg::instr_t make_instr(input core_pkg::opcode_e opcode,
            input logic [3:0] dest, input logic [3:0] src_a, input logic [3:0] src_b,
            input logic [11:0] imm);
        core_pkg::instr_t instr;
        instr.opcode = opcode;
        instr.dest   = dest;
        instr.src_a  = src_a;
        instr.src_b  = src_b;
        instr.spare  = '0;
        instr.imm    = imm;
        return instr;
    endfunction

    // Draws the fields in a fixed order from opcode to imm
    function automatic core_pkg::instr_t random_instr();
        core_pkg::opcode_e opcode;
        logic [3:0]        dest;
        logic [3:0]        src_a;
        logic [3:0]        src_b;
        logic [11:0]       imm;
        opcode = core_pkg::opcode_e'(random_bits(4) % 9);
        dest   = 4'(random_bits(4));
        src_a  = 4'(random_bits(4));
        src_b  = 4'(random_bits(4));
        imm    = 12'(random_bits(12));
        return make_instr(opcode, dest, src_a, src_b, imm);
    endfunction

    // Each channel runs the program alone up to the first stop word
    function automatic void run_model(input logic [1:0] last_channel);
        core_pkg::instr_t instr;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      value;
        logic [1:0]       chan;
        logic             writes;
        logic             stopped;
        for (int ch = 0; ch <= int'(last_channel); ch++) begin
            chan    = 2'(ch);
            stopped = 1'b0;
            for (int pc = 0; pc < core_pkg::prog_depth && !stopped; pc++) begin
                instr  = prog_mem[pc];
                a      = model_regs[{chan, instr.src_a}];
                b      = model_regs[{chan, instr.src_b}];
                writes = 1'b1;
                value  = '0;
                case (instr.opcode)
                    core_pkg::op_add: value = a + b;
                    core_pkg::op_sub: value = a - b;
                    core_pkg::op_and: value = a & b;
                    core_pkg::op_or:  value = a | b;
                    core_pkg::op_xor: value = a ^ b;
                    core_pkg::op_shl: value = a << b[4:0];
                    core_pkg::op_shr: value = a >> b[4:0];
                    core_pkg::op_ldi: value = {20'h0, instr.imm};
                    default:          writes = 1'b0;
                endcase
                if (instr.opcode == core_pkg::op_stop) begin
                    stopped = 1'b1;
                end else if (writes) begin
                    model_regs[{chan, instr.dest}] = value;
                end
            end
        end
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
            input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s read %h, expected %h", $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    // Words past the program body load an address-derived value
    function automatic void fill_program();
        for (int addr = 0; addr < core_pkg::prog_depth; addr++) begin
            prog_mem[addr] = make_instr(core_pkg::op_ldi, 4'(addr), '0, '0, 12'(addr * 37 + 5));
        end
    endfunction

    task automatic load_program();
        for (int addr = 0; addr < core_pkg::prog_depth; addr++) begin
            @(negedge clock);
            prog_write = 1'b1;
            prog_addr  = 6'(addr);
            prog_data  = prog_mem[addr];
        end
        @(negedge clock);
        prog_write = 1'b0;
    endtask

    task automatic preload_banks();
        for (int addr = 0; addr < bank_words; addr++) begin
            @(negedge clock);
            model_regs[addr] = random_bits(32);
            reg_write        = 1'b1;
            reg_channel      = 2'(addr >> 4);
            reg_addr         = 4'(addr);
            reg_wdata        = model_regs[addr];
        end
        @(negedge clock);
        reg_write = 1'b0;
    endtask

    // Reads every bank back while checking that done stays low
    task automatic compare_banks(input string test_name);
        for (int addr = 0; addr < bank_words; addr++) begin
            @(negedge clock);
            reg_channel = 2'(addr >> 4);
            reg_addr    = 4'(addr);
            @(posedge clock);
            check_value(32'(done), 32'd0, {test_name, " done while idle"});
            check_value(reg_rdata, model_regs[addr],
                        $sformatf("%s ch%0d r%0d", test_name, addr >> 4, addr % 16));
        end
    endtask

    task automatic execute(input logic [1:0] last_channel, input string test_name);
        int unsigned waited;
        load_program();
        run_model(last_channel);
        @(negedge clock);
        n_channels = last_channel;
        run        = 1'b1;
        @(negedge clock);
        run    = 1'b0;
        waited = 0;
        while (!done && waited < done_timeout) begin
            @(negedge clock);
            waited++;
        end
        if (!done) begin
            $display("%s: done did not arrive within %0d cycles", test_name, done_timeout);
            $display("*** FAILED ***");
            $fatal(1, "run did not finish");
        end
        compare_banks(test_name);
    endtask

    initial begin
        repeat (num_runs * run_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles", num_runs * run_cycles);
        $display("*** FAILED ***");
        $fatal(1, "simulation timeout");
    end

    // A failed property in the bound checker ends the run
    always @(posedge clock) begin
        if (i_dut.i_props.error_count != 0) begin
            $display("a bound property check failed");
            $display("*** FAILED ***");
            $fatal(1, "property failure");
        end
    end

    initial begin
        lfsr_state  = 16'(78611);
        rst_n       = 1'b0;
        prog_write  = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        reg_write   = 1'b0;
        reg_channel = '0;
        reg_addr    = '0;
        reg_wdata   = '0;
        n_channels  = '0;
        run         = 1'b0;
        for (int addr = 0; addr < bank_words; addr++) begin
            model_regs[addr] = '0;
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        compare_banks("reset");

        ////////////////////////////////////////////////////////////////////////
        // Directed opcode program over all four channels
        ////////////////////////////////////////////////////////////////////////
        preload_banks();
        fill_program();
        prog_mem[0]  = make_instr(core_pkg::op_ldi, 4'd1, 4'd0, 4'd0, 12'h5a3);
        prog_mem[1]  = make_instr(core_pkg::op_ldi, 4'd2, 4'd0, 4'd0, 12'h0f1);
        prog_mem[2]  = make_instr(core_pkg::op_add, 4'd3, 4'd1, 4'd2, 12'h0);
        prog_mem[3]  = make_instr(core_pkg::op_sub, 4'd4, 4'd2, 4'd1, 12'h0);
        prog_mem[4]  = make_instr(core_pkg::op_and, 4'd5, 4'd1, 4'd2, 12'h0);
        prog_mem[5]  = make_instr(core_pkg::op_or,  4'd6, 4'd1, 4'd2, 12'h0);
        prog_mem[6]  = make_instr(core_pkg::op_xor, 4'd7, 4'd1, 4'd2, 12'h0);
        prog_mem[7]  = make_instr(core_pkg::op_ldi, 4'd8, 4'd0, 4'd0, 12'h003);
        prog_mem[8]  = make_instr(core_pkg::op_shl, 4'd9, 4'd1, 4'd8, 12'h0);
        prog_mem[9]  = make_instr(core_pkg::op_shr, 4'd10, 4'd4, 4'd8, 12'h0);
        prog_mem[10] = make_instr(core_pkg::op_nop, 4'd11, 4'd1, 4'd2, 12'hfff);
        prog_mem[11] = make_instr(core_pkg::op_stop, 4'd0, 4'd0, 4'd0, 12'h0);
        execute(2'd3, "opcodes");

        // Preloaded operands with the channel count swept
        fill_program();
        prog_mem[0] = make_instr(core_pkg::op_add, 4'd12, 4'd0, 4'd1, 12'h0);
        prog_mem[1] = make_instr(core_pkg::op_xor, 4'd13, 4'd2, 4'd3, 12'h0);
        prog_mem[2] = make_instr(core_pkg::op_sub, 4'd14, 4'd12, 4'd13, 12'h0);
        prog_mem[3] = make_instr(core_pkg::op_shr, 4'd15, 4'd14, 4'd4, 12'h0);
        prog_mem[4] = make_instr(core_pkg::op_stop, 4'd0, 4'd0, 4'd0, 12'h0);
        for (int ch = 0; ch < core_pkg::max_channels; ch++) begin
            preload_banks();
            execute(2'(ch), $sformatf("channels %0d", ch + 1));
        end

        // Dependent chain on one channel where every step stalls
        preload_banks();
        fill_program();
        prog_mem[0] = make_instr(core_pkg::op_ldi, 4'd1, 4'd0, 4'd0, 12'h005);
        prog_mem[1] = make_instr(core_pkg::op_add, 4'd2, 4'd1, 4'd1, 12'h0);
        prog_mem[2] = make_instr(core_pkg::op_add, 4'd3, 4'd2, 4'd1, 12'h0);
        prog_mem[3] = make_instr(core_pkg::op_sub, 4'd4, 4'd3, 4'd2, 12'h0);
        prog_mem[4] = make_instr(core_pkg::op_xor, 4'd5, 4'd4, 4'd3, 12'h0);
        prog_mem[5] = make_instr(core_pkg::op_shl, 4'd6, 4'd5, 4'd1, 12'h0);
        prog_mem[6] = make_instr(core_pkg::op_stop, 4'd0, 4'd0, 4'd0, 12'h0);
        execute(2'd0, "hazards");

        ////////////////////////////////////////////////////////////////////////
        // Random programs with the stop word at a random position
        ////////////////////////////////////////////////////////////////////////
        for (int prog = 0; prog < 20; prog++) begin
            preload_banks();
            for (int addr = 0; addr < core_pkg::prog_depth; addr++) begin
                prog_mem[addr] = random_instr();
            end
            stop_pos           = random_bits(6);
            prog_mem[stop_pos] = make_instr(core_pkg::op_stop, '0, '0, '0, '0);
            execute(2'(random_bits(2)), $sformatf("random %0d", prog));
        end

        if (i_dut.i_props.error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/core_pkg.sv
hw/program_store.sv
hw/sequencer.sv
hw/decoder.sv
hw/executor.sv
hw/register_file.sv
hw/core_top.sv
tb/core_props.sv
tb/core_tb.sv

//--- Bender.yml
package:
  name: core

sources:
  # Package first, the RTL depends on it
  - hw/core_pkg.sv
  - hw/program_store.sv
  - hw/sequencer.sv
  - hw/decoder.sv
  - hw/executor.sv
  - hw/register_file.sv
  - hw/core_top.sv

  - target: test
    files:
      - tb/core_props.sv
      - tb/core_tb.sv
